// ==== include/l1_defines.svh ====
`ifndef L1_DEFINES_SVH
`define L1_DEFINES_SVH

// word address into the bank, 16 words
`define L1_ADDR_W     4
`define L1_DATA_W     32
`define L1_BANK_WORDS 16

// reads issued per prefetch burst
`define L1_PF_DEPTH   3

// request source tag
`define L1_SID_W      2

// completed prefetch counter, wraps
`define L1_STATUS_W   8

`endif

// ==== rtl/l1_pkg.sv ====
`include "l1_defines.svh"

package l1_pkg;

  typedef logic [`L1_ADDR_W-1:0] l1_addr_t;
  typedef logic [`L1_DATA_W-1:0] l1_data_t;

  // who issued a bank request
  typedef enum logic [`L1_SID_W-1:0] {
    SID_LOAD     = 2'd0,
    SID_STORE    = 2'd1,
    SID_PREFETCH = 2'd2
  } l1_sid_t;

  // port payloads, addr is always the top field
  typedef struct packed {
    l1_addr_t addr;
  } l1_rd_req_t;

  typedef struct packed {
    l1_addr_t addr;
    l1_data_t data;
  } l1_wr_req_t;

  typedef struct packed {
    l1_sid_t  sid;
    logic     we;    // write, no response
    l1_addr_t addr;
    l1_data_t data;
  } l1_mem_req_t;

  typedef struct packed {
    l1_sid_t  sid;
    l1_data_t data;
  } l1_rsp_t;

endpackage

// ==== rtl/mem_req_if.sv ====
`timescale 1ns/1ns

interface mem_req_if import l1_pkg::*; ();

  logic        valid;
  logic        ready;
  l1_mem_req_t req;

  // requester holds req stable while valid && !ready
  modport requester (
    output valid,
    output req,
    input  ready
  );

  modport arbiter (
    input  valid,
    input  req,
    output ready
  );

endinterface

// ==== rtl/req_port_buffer.sv ====
`timescale 1ns/1ns
`include "l1_defines.svh"

module req_port_buffer import l1_pkg::*; #(
  parameter type     payload_t = l1_rd_req_t,
  parameter l1_sid_t SID       = SID_LOAD
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         in_valid_i,
  input  payload_t     in_payload_i,
  output logic         in_ready_o,
  output logic         fire_o,
  mem_req_if.requester out
);

  localparam int PW       = $bits(payload_t);
  localparam bit HAS_DATA = PW > `L1_ADDR_W;  // write port payload

  logic          full_q;
  payload_t      held_q;
  logic [PW-1:0] held_bits;
  l1_data_t      held_data;

  // free slot, or the held entry leaves this cycle
  assign in_ready_o = ~full_q | out.ready;
  assign fire_o     = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (fire_o) begin
      full_q <= 1'b1;
    end else if (out.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire_o) begin
      held_q <= in_payload_i;
    end
  end

  assign held_bits = held_q;

  if (HAS_DATA) begin : g_data
    assign held_data = held_bits[`L1_DATA_W-1:0];
  end else begin : g_no_data
    assign held_data = '0;
  end

  assign out.valid = full_q;
  assign out.req   = '{sid:  SID,
                       we:   HAS_DATA,
                       addr: held_bits[PW-1 -: `L1_ADDR_W],
                       data: held_data};

endmodule

// ==== rtl/stride_prefetcher.sv ====
`timescale 1ns/1ns
`include "l1_defines.svh"

module stride_prefetcher import l1_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    base_set_i,
  input  l1_addr_t                base_i,
  input  logic                    stride_set_i,
  input  l1_addr_t                stride_i,
  output l1_addr_t                base_o,
  output l1_addr_t                stride_o,
  input  logic                    snoop_valid_i,
  input  l1_addr_t                snoop_addr_i,
  input  logic                    pf_rsp_valid_i,
  output logic [`L1_STATUS_W-1:0] status_o,
  mem_req_if.requester            req
);

  localparam int CNT_W = $clog2(`L1_PF_DEPTH + 1);

  l1_addr_t                base_q, stride_q;
  l1_addr_t                pf_addr_q;
  logic                    armed_q, active_q;
  logic [CNT_W-1:0]        cnt_q;     // reads accepted in this burst
  logic [`L1_STATUS_W-1:0] status_q;
  logic                    snoop_hit, pf_fire, last_rd;

  assign snoop_hit = armed_q & ~active_q & snoop_valid_i & (snoop_addr_i == base_q);
  assign pf_fire   = req.valid & req.ready;
  assign last_rd   = pf_fire & (cnt_q == CNT_W'(`L1_PF_DEPTH - 1));

  ////////////////////
  // config registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q   <= '0;
      stride_q <= '0;
    end else begin
      if (base_set_i)   base_q   <= base_i;
      if (stride_set_i) stride_q <= stride_i;
    end
  end

  ////////////////////
  // burst control
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q  <= 1'b0;
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      if (base_set_i) begin
        armed_q <= 1'b1;  // rearm on every base write
      end else if (last_rd) begin
        armed_q <= 1'b0;
      end
      if (snoop_hit) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (pf_fire) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_rd) active_q <= 1'b0;
      end
    end
  end

  // addresses wrap with the bank depth
  always_ff @(posedge clk_i) begin
    if (snoop_hit) begin
      pf_addr_q <= base_q + stride_q;
    end else if (pf_fire) begin
      pf_addr_q <= pf_addr_q + stride_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) status_q <= '0;
    else if (pf_rsp_valid_i) status_q <= status_q + 1'b1;
  end

  assign req.valid = active_q;
  assign req.req   = '{sid: SID_PREFETCH, we: 1'b0, addr: pf_addr_q, data: '0};

  assign base_o   = base_q;
  assign stride_o = stride_q;
  assign status_o = status_q;

endmodule

// ==== rtl/req_arbiter.sv ====
`timescale 1ns/1ns

module req_arbiter import l1_pkg::*; (
  mem_req_if.arbiter  store_req,
  mem_req_if.arbiter  load_req,
  mem_req_if.arbiter  pf_req,
  output logic        bank_valid_o,
  output l1_mem_req_t bank_req_o
);

  logic gnt_store, gnt_load, gnt_pf;

  ////////////////////
  // fixed priority, store > load > prefetch
  assign gnt_store = store_req.valid;
  assign gnt_load  = load_req.valid & ~store_req.valid;
  assign gnt_pf    = pf_req.valid & ~store_req.valid & ~load_req.valid;

  // bank takes one request every cycle
  assign store_req.ready = gnt_store;
  assign load_req.ready  = gnt_load;
  assign pf_req.ready    = gnt_pf;

  assign bank_valid_o = gnt_store | gnt_load | gnt_pf;

  always_comb begin
    bank_req_o = '0;
    if (gnt_store) begin
      bank_req_o = store_req.req;
    end else if (gnt_load) begin
      bank_req_o = load_req.req;
    end else if (gnt_pf) begin
      bank_req_o = pf_req.req;
    end
  end

endmodule

// ==== rtl/data_bank.sv ====
`timescale 1ns/1ns
`include "l1_defines.svh"

module data_bank import l1_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  l1_mem_req_t req_i,
  output logic        rsp_valid_o,
  output l1_rsp_t     rsp_o
);

  l1_data_t mem_q [`L1_BANK_WORDS];
  logic     rsp_valid_q;
  l1_rsp_t  rsp_q;

  // bank contents start at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `L1_BANK_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_valid_i && req_i.we) begin
      mem_q[req_i.addr] <= req_i.data;
    end
  end

  // reads only, writes are silent
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rsp_valid_q <= 1'b0;
    else         rsp_valid_q <= req_valid_i & ~req_i.we;
  end

  always_ff @(posedge clk_i) begin
    rsp_q.sid  <= req_i.sid;
    rsp_q.data <= mem_q[req_i.addr];
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

// ==== rtl/resp_router.sv ====
`timescale 1ns/1ns

module resp_router import l1_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     rsp_valid_i,
  input  l1_rsp_t  rsp_i,
  output logic     load_rsp_valid_o,
  output l1_data_t load_rsp_data_o,
  output logic     pf_rsp_valid_o,
  input  logic     flush_i,
  output logic     flush_ack_o
);

  logic flush_ack_q;

  ////////////////////
  // response decode
  assign load_rsp_valid_o = rsp_valid_i & (rsp_i.sid == SID_LOAD);
  assign load_rsp_data_o  = rsp_i.data;

  // completion strobe for the status count
  assign pf_rsp_valid_o = rsp_valid_i & (rsp_i.sid == SID_PREFETCH);

  ////////////////////
  // flush ack

  // nothing to write back, ack right away
  // holding flush_i gives a pulse every other cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_ack_q <= 1'b0;
    end else begin
      flush_ack_q <= ~flush_ack_q & flush_i;
    end
  end

  assign flush_ack_o = flush_ack_q;

endmodule

// ==== rtl/l1_req_subsystem.sv ====
`timescale 1ns/1ns
`include "l1_defines.svh"

module l1_req_subsystem import l1_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // load port
  input  logic                    load_valid_i,
  input  l1_addr_t                load_addr_i,
  output logic                    load_ready_o,
  output logic                    load_rsp_valid_o,
  output l1_data_t                load_rsp_data_o,

  // store port
  input  logic                    store_valid_i,
  input  l1_addr_t                store_addr_i,
  input  l1_data_t                store_data_i,
  output logic                    store_ready_o,

  // prefetcher config and status
  input  logic                    pf_base_set_i,
  input  l1_addr_t                pf_base_i,
  output l1_addr_t                pf_base_o,
  input  logic                    pf_stride_set_i,
  input  l1_addr_t                pf_stride_i,
  output l1_addr_t                pf_stride_o,
  output logic [`L1_STATUS_W-1:0] pf_status_o,

  input  logic                    flush_i,
  output logic                    flush_ack_o
);

  l1_rd_req_t  load_req;
  l1_wr_req_t  store_req;
  logic        load_fire;
  logic        bank_valid;
  l1_mem_req_t bank_req;
  logic        rsp_valid;
  l1_rsp_t     rsp;
  logic        pf_rsp_valid;

  mem_req_if load_if ();
  mem_req_if store_if ();
  mem_req_if pf_if ();

  assign load_req.addr  = load_addr_i;
  assign store_req.addr = store_addr_i;
  assign store_req.data = store_data_i;

  ////////////////////
  // port buffers
  req_port_buffer #(
    .payload_t (l1_rd_req_t),
    .SID       (SID_LOAD)
  ) i_load_buf (
    .clk_i,
    .rst_ni,
    .in_valid_i   (load_valid_i),
    .in_payload_i (load_req),
    .in_ready_o   (load_ready_o),
    .fire_o       (load_fire),
    .out          (load_if.requester)
  );

  req_port_buffer #(
    .payload_t (l1_wr_req_t),
    .SID       (SID_STORE)
  ) i_store_buf (
    .clk_i,
    .rst_ni,
    .in_valid_i   (store_valid_i),
    .in_payload_i (store_req),
    .in_ready_o   (store_ready_o),
    .fire_o       (),
    .out          (store_if.requester)
  );

  // snoops loads as they enter the buffer
  stride_prefetcher i_prefetcher (
    .clk_i,
    .rst_ni,
    .base_set_i     (pf_base_set_i),
    .base_i         (pf_base_i),
    .stride_set_i   (pf_stride_set_i),
    .stride_i       (pf_stride_i),
    .base_o         (pf_base_o),
    .stride_o       (pf_stride_o),
    .snoop_valid_i  (load_fire),
    .snoop_addr_i   (load_addr_i),
    .pf_rsp_valid_i (pf_rsp_valid),
    .status_o       (pf_status_o),
    .req            (pf_if.requester)
  );

  ////////////////////
  // arbitration and bank
  req_arbiter i_arbiter (
    .store_req    (store_if.arbiter),
    .load_req     (load_if.arbiter),
    .pf_req       (pf_if.arbiter),
    .bank_valid_o (bank_valid),
    .bank_req_o   (bank_req)
  );

  data_bank i_bank (
    .clk_i,
    .rst_ni,
    .req_valid_i (bank_valid),
    .req_i       (bank_req),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  resp_router i_router (
    .clk_i,
    .rst_ni,
    .rsp_valid_i      (rsp_valid),
    .rsp_i            (rsp),
    .load_rsp_valid_o (load_rsp_valid_o),
    .load_rsp_data_o  (load_rsp_data_o),
    .pf_rsp_valid_o   (pf_rsp_valid),
    .flush_i          (flush_i),
    .flush_ack_o      (flush_ack_o)
  );

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD = 8
) (
  output logic clk_o
);

  // free running, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// ==== testbench/tb_l1_req_subsystem.sv ====
`timescale 1ns/1ns
`include "l1_defines.svh"

module tb_l1_req_subsystem import l1_pkg::*; ();

  typedef enum int {OP_LOAD, OP_STORE, OP_PAIR, OP_PFCFG, OP_FLUSH} op_e;

  logic                    clk, rst_n;
  logic                    load_valid, load_ready, load_rsp_valid;
  l1_addr_t                load_addr;
  l1_data_t                load_rsp_data;
  logic                    store_valid, store_ready;
  l1_addr_t                store_addr;
  l1_data_t                store_data;
  logic                    pf_base_set, pf_stride_set;
  l1_addr_t                pf_base, pf_stride, pf_base_rd, pf_stride_rd;
  logic [`L1_STATUS_W-1:0] pf_status, status_exp;
  logic                    flush, flush_ack;

  // stimulus table, one column per queue
  op_e      op_q[$];
  l1_addr_t addr_q[$];   // flush: cycles to hold flush
  l1_data_t data_q[$];   // pfcfg: stride
  int       exp_q[$];    // expected pf_status increase
  l1_data_t ref_mem [`L1_BANK_WORDS];
  logic [31:0] lcg_state;
  int       cycle_cnt = 0;
  int       cycle_limit = 0;

  tb_clock #(.PERIOD(8)) i_clk (.clk_o(clk));

  l1_req_subsystem uut (
    .clk_i (clk), .rst_ni (rst_n),
    .load_valid_i (load_valid), .load_addr_i (load_addr), .load_ready_o (load_ready),
    .load_rsp_valid_o (load_rsp_valid), .load_rsp_data_o (load_rsp_data),
    .store_valid_i (store_valid), .store_addr_i (store_addr),
    .store_data_i (store_data), .store_ready_o (store_ready),
    .pf_base_set_i (pf_base_set), .pf_base_i (pf_base), .pf_base_o (pf_base_rd),
    .pf_stride_set_i (pf_stride_set), .pf_stride_i (pf_stride),
    .pf_stride_o (pf_stride_rd), .pf_status_o (pf_status),
    .flush_i (flush), .flush_ack_o (flush_ack)
  );

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // inputs change and outputs are read 1 ns after the edge
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic add_entry(input op_e op, input l1_addr_t a, input l1_data_t d, input int e);
    op_q.push_back(op);
    addr_q.push_back(a);
    data_q.push_back(d);
    exp_q.push_back(e);
  endtask

  task automatic issue_store(input l1_addr_t a, input l1_data_t d);
    store_valid = 1'b1;
    store_addr  = a;
    store_data  = d;
    while (!store_ready) step_cycle();
    step_cycle();  // accepted on this edge
    store_valid = 1'b0;
    ref_mem[a]  = d;
  endtask

  task automatic issue_load(input l1_addr_t a);
    load_valid = 1'b1;
    load_addr  = a;
    while (!load_ready) step_cycle();
    step_cycle();
    load_valid = 1'b0;
  endtask

  task automatic wait_load_rsp(input l1_addr_t a);
    while (!load_rsp_valid) step_cycle();
    check_eq(load_rsp_data, ref_mem[a], $sformatf("load data at word %0d", a));
    step_cycle();
  endtask

  // wait for the burst to drain, then make sure nothing more arrives
  task automatic check_status(input logic [`L1_STATUS_W-1:0] exp);
    while (pf_status != exp) step_cycle();
    repeat (6) step_cycle();
    check_eq(pf_status, exp, "pf_status");
  endtask

  task automatic program_prefetch(input l1_addr_t base, input l1_addr_t stride);
    pf_base_set   = 1'b1;
    pf_base       = base;
    pf_stride_set = 1'b1;
    pf_stride     = stride;
    step_cycle();
    pf_base_set   = 1'b0;
    pf_stride_set = 1'b0;
    check_eq(pf_base_rd, base, "pf_base readback");
    check_eq(pf_stride_rd, stride, "pf_stride readback");
  endtask

  ////////////////////
  // flush ack model, one pulse then one idle cycle
  task automatic run_flush(input int hold);
    logic ack_model;
    ack_model = 1'b0;
    flush     = 1'b1;
    repeat (hold) begin
      check_eq(flush_ack, ack_model, "flush_ack while flushing");
      step_cycle();
      ack_model = ~ack_model;
    end
    check_eq(flush_ack, ack_model, "flush_ack while flushing");
    flush = 1'b0;
    repeat (2) begin
      step_cycle();
      check_eq(flush_ack, 1'b0, "flush_ack after flush drops");
    end
  endtask

  initial begin
    rst_n = 1'b0;
    {load_valid, store_valid, pf_base_set, pf_stride_set, flush} = '0;
    load_addr  = '0;
    store_addr = '0;
    store_data = '0;
    pf_base    = '0;
    pf_stride  = '0;
    lcg_state  = 32'd34;
    status_exp = '0;  // count is zero out of reset
    for (int i = 0; i < `L1_BANK_WORDS; i++) ref_mem[i] = '0;

    add_entry(OP_LOAD, 4'd5, 0, 0);   // never written
    add_entry(OP_STORE, 4'd1, 0, 0);
    add_entry(OP_STORE, 4'd2, 0, 0);
    add_entry(OP_STORE, 4'd7, 0, 0);
    add_entry(OP_STORE, 4'd14, 0, 0);
    add_entry(OP_LOAD, 4'd1, 0, 0);
    add_entry(OP_LOAD, 4'd7, 0, 0);
    add_entry(OP_LOAD, 4'd2, 0, 0);
    add_entry(OP_LOAD, 4'd14, 0, 0);
    add_entry(OP_PAIR, 4'd7, 0, 0);   // store wins the bank
    add_entry(OP_PFCFG, 4'd3, 5, 0);  // reads 8, 13, 2
    add_entry(OP_LOAD, 4'd3, 0, `L1_PF_DEPTH);
    add_entry(OP_LOAD, 4'd3, 0, 0);   // disarmed now
    add_entry(OP_LOAD, 4'd1, 0, 0);
    add_entry(OP_FLUSH, 4'd6, 0, 0);
    cycle_limit = 40 * op_q.size();

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    foreach (op_q[i]) begin
      status_exp = status_exp + exp_q[i];
      case (op_q[i])
        OP_STORE: begin
          lcg_state = lcg_next(lcg_state);
          issue_store(addr_q[i], lcg_state);
        end
        OP_LOAD: begin
          issue_load(addr_q[i]);
          wait_load_rsp(addr_q[i]);
          check_status(status_exp);
        end
        OP_PAIR: begin
          lcg_state   = lcg_next(lcg_state);
          store_valid = 1'b1;
          store_addr  = addr_q[i];
          store_data  = lcg_state;
          load_valid  = 1'b1;
          load_addr   = addr_q[i];
          while (!(store_ready && load_ready)) step_cycle();
          step_cycle();  // both taken on the same edge
          store_valid = 1'b0;
          load_valid  = 1'b0;
          // load entry waits behind the store, store entry drains now
          check_eq(load_ready, 1'b0, "load_ready with its entry waiting");
          check_eq(store_ready, 1'b1, "store_ready with its entry granted");
          ref_mem[addr_q[i]] = lcg_state;
          wait_load_rsp(addr_q[i]);
        end
        OP_PFCFG: program_prefetch(addr_q[i], data_q[i][`L1_ADDR_W-1:0]);
        OP_FLUSH: run_flush(addr_q[i]);
        default: ;
      endcase
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
rtl/l1_pkg.sv
rtl/mem_req_if.sv
rtl/req_port_buffer.sv
rtl/stride_prefetcher.sv
rtl/req_arbiter.sv
rtl/data_bank.sv
rtl/resp_router.sv
rtl/l1_req_subsystem.sv
testbench/tb_clock.sv
testbench/tb_l1_req_subsystem.sv
